// ==== sim.f ====
+incdir+include
verilog/dct_pkg.sv
verilog/dct_row_stage.sv
verilog/dct_col_stage.sv
verilog/y_dct.sv
testbench/tb_y_dct.sv

// ==== Makefile ====
# Verilator simulation of the luminance 8x8 DCT

TOP := tb_y_dct

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if sim.log holds the pass message"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== include/dct_ref_model.svh ====
// Testbench model types and functions for the DCT cosine table, row pass and column pass
`ifndef DCT_REF_MODEL_SVH
`define DCT_REF_MODEL_SVH

// One row of values and one full block, indexed [row][column]
typedef int model_row_t [8];
typedef int model_blk_t [8][8];

// Cosine constant scaled by 8192 and taken from the real cosine
// DC uses 1/sqrt(2) in the same scaling
function automatic int scaled_cos(input int k, input int n);
	real c;
	if (k == 0) begin
		return 5793;
	end
	c = 8192.0 * $cos(real'((2 * n + 1) * k) * 3.14159265358979 / 16.0);
	// Round to nearest with ties away from zero
	return $rtoi(c + ((c >= 0.0) ? 0.5 : -0.5));
endfunction

// Keep the low w bits of v as a signed value, as a w-bit register would
function automatic int wrap_to_width(input longint v, input int w);
	longint t;
	t = v <<< (64 - w);
	return int'(t >>> (64 - w));
endfunction

// Row pass over eight raw pixels
// The sum is cut by 12 bits and rounded half up with bit 11
function automatic model_row_t row_pass(input model_row_t pix);
	model_row_t y;
	longint     r;
	for (int k = 0; k < 8; k++) begin
		r = 0;
		for (int n = 0; n < 8; n++) begin
			r += longint'(scaled_cos(k, n)) * longint'(pix[n] - 128);
		end
		y[k] = wrap_to_width((r >>> 12) + ((r >>> 11) & 1), 13);
	end
	return y;
endfunction

// Column pass over the eight row results of one block
// Result [v][u] is cut by 16 bits, rounded with bit 15 and kept to 11 bits
function automatic model_blk_t column_pass(input model_blk_t y);
	model_blk_t z;
	longint     c;
	for (int v = 0; v < 8; v++) begin
		for (int u = 0; u < 8; u++) begin
			c = 0;
			for (int r = 0; r < 8; r++) begin
				c += longint'(scaled_cos(v, r)) * longint'(y[r][u]);
			end
			z[v][u] = wrap_to_width((c >>> 16) + ((c >>> 15) & 1), 11);
		end
	end
	return z;
endfunction

`endif

// ==== testbench/tb_y_dct.sv ====
// Testbench for the luminance DCT with clock, reset, xorshift stimulus, block scoreboard and timeout
module tb_y_dct import dct_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	`include "dct_ref_model.svh"

	// Reset, flat blocks, random blocks, interruption, recovery, drain and hold
	localparam int FEED_CYCLES    = 16 + 3 * 64 + 20 * 64 + 1 + 63 + 2 + 64 + 64 + 1 + 8 + 21;
	localparam int TIMEOUT_CYCLES = 2 * FEED_CYCLES + 200;

	logic        clk;
	logic        rst;
	logic        enable;
	pixel_t      data_in;
	logic        output_enable;
	coef_block_t coef_block;

	// Rising edges seen since time zero
	int          cycle_count;
	logic [31:0] rng_state;
	logic        prev_oe;

	// Pixels of the block being fed and the block the DUT must produce for it
	model_blk_t  pixels;
	model_blk_t  expected_blk;

	// The scoreboard holds one pulse edge and 64 coefficients per completed block
	int          expected_edges [$];
	int          expected_coefs [$];

	y_dct y_dct_i (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.data_in       (data_in),
		.output_enable (output_enable),
		.coef_block    (coef_block)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// -------------------------------------------------------------------------
	// Helpers
	// -------------------------------------------------------------------------

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Classic 32-bit xorshift step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic draw_random(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state;
	endtask

	// A flat block has only a DC term whose value is known in closed form
	task automatic make_flat(input int value, input int dc);
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				pixels[r][c] = value;
				expected_blk[r][c] = (r == 0 && c == 0) ? dc : 0;
			end
		end
	endtask

	// Draw random pixels and build the expected block with the row and column pass model
	task automatic make_random();
		logic [31:0] value;
		model_row_t  in_row;
		model_row_t  out_row;
		model_blk_t  y;
		for (int r = 0; r < 8; r++) begin
			for (int n = 0; n < 8; n++) begin
				draw_random(value);
				pixels[r][n] = int'(value[7:0]);
				in_row[n] = pixels[r][n];
			end
			out_row = row_pass(in_row);
			for (int k = 0; k < 8; k++) begin
				y[r][k] = out_row[k];
			end
		end
		expected_blk = column_pass(y);
	endtask

	// Drives count pixels of the block in raster order with enable held high
	// Only a full block is expected to come out
	task automatic feed_block(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			#1;
			enable  = 1'b1;
			data_in = pixel_t'(pixels[i / 8][i % 8]);
		end
		if (count == 64) begin
			// The last pixel is sampled at the next edge and the pulse follows six edges later
			expected_edges.push_back(cycle_count + 7);
			for (int v = 0; v < 8; v++) begin
				for (int u = 0; u < 8; u++) begin
					expected_coefs.push_back(expected_blk[v][u]);
				end
			end
		end
	endtask

	task automatic go_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#1;
			enable  = 1'b0;
			data_in = '0;
		end
	endtask

	// Pops one block and compares pulse edge and all 64 coefficients
	task automatic check_pulse();
		int        exp_edge;
		int        want;
		dct_coef_t got;
		assert (expected_edges.size() != 0) else
			stop_with_failure("output_enable pulsed with no completed block outstanding");
		exp_edge = expected_edges.pop_front();
		assert (cycle_count == exp_edge) else
			stop_with_failure($sformatf(
				"MISMATCH at %0t: output_enable at edge %0d, expected edge %0d",
				$time, cycle_count, exp_edge));
		for (int v = 0; v < BLOCK_N; v++) begin
			for (int u = 0; u < BLOCK_N; u++) begin
				want = expected_coefs.pop_front();
				got  = coef_block[(v * BLOCK_N + u) * DCT_COEF_W +: DCT_COEF_W];
				assert (int'(got) == want) else
					stop_with_failure($sformatf(
						"MISMATCH at %0t: coefficient v=%0d u=%0d got %0d expected %0d",
						$time, v, u, int'(got), want));
			end
		end
	endtask

	// -------------------------------------------------------------------------
	// Monitors
	// -------------------------------------------------------------------------

	// Edge counter and run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			stop_with_failure("Timeout: the run did not finish within the cycle limit");
		end
	end

	// Outputs only change on rising edges, so they are sampled on falling edges
	always @(negedge clk) begin
		if (rst) begin
			assert (!output_enable) else
				stop_with_failure("output_enable was high while reset was asserted");
		end else if (output_enable) begin
			assert (!prev_oe) else
				stop_with_failure("output_enable stayed high for more than one cycle");
			check_pulse();
		end
		prev_oe = output_enable;
	end

	// -------------------------------------------------------------------------
	// Stimulus
	// -------------------------------------------------------------------------

	initial begin
		int          stop_at;
		int          wait_left;
		logic [31:0] value;
		coef_block_t held;
		rst         = 1'b1;
		enable      = 1'b0;
		data_in     = '0;
		cycle_count = 0;
		prev_oe     = 1'b0;
		rng_state   = 32'd24;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		// Flat blocks lead straight into twenty random ones with no gap
		make_flat(128, 0);
		feed_block(64);
		make_flat(0, -1024);
		feed_block(64);
		make_flat(255, 1016);
		feed_block(64);
		repeat (20) begin
			make_random();
			feed_block(64);
		end

		// Block cut short somewhere in pixels 1 to 63, then a full block
		go_idle(1);
		make_random();
		draw_random(value);
		stop_at = 1 + int'(value % 32'd63);
		feed_block(stop_at);
		go_idle(2);
		make_random();
		feed_block(64);

		// Input stops right after the last pixel of this block
		make_random();
		feed_block(64);
		go_idle(1);
		// The drained block is due seven falling edges from here
		wait_left = 10;
		while (expected_edges.size() != 0 && wait_left > 0) begin
			@(negedge clk);
			wait_left--;
		end
		@(negedge clk);
		held = coef_block;
		repeat (20) begin
			@(negedge clk);
			assert (coef_block == held) else
				stop_with_failure($sformatf(
					"MISMATCH at %0t: coef_block changed while idle", $time));
		end

		if (expected_edges.size() == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stop_with_failure("Blocks were still outstanding at the end of the run");
		end
	end

endmodule

// ==== verilog/y_dct.sv ====
// Top level of the luminance 8x8 forward DCT joining the row pass and the column pass
module y_dct import dct_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        enable,
	input  pixel_t      data_in,
	output logic        output_enable,
	output coef_block_t coef_block
);

	// Row results handed from the row pass to the column pass
	row_vec_t row_coefs;
	idx_t     row_idx;
	logic     row_valid;

	// Row pass, one pixel per enabled clock in raster order
	dct_row_stage row_stage_i (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.data_in   (data_in),
		.row_coefs (row_coefs),
		.row_idx   (row_idx),
		.row_valid (row_valid)
	);

	// Column pass, one update per completed row
	dct_col_stage col_stage_i (
		.clk           (clk),
		.rst           (rst),
		.row_coefs     (row_coefs),
		.row_idx       (row_idx),
		.row_valid     (row_valid),
		.coef_block    (coef_block),
		.output_enable (output_enable)
	);

endmodule

// ==== verilog/dct_col_stage.sv ====
// Column pass of the 8x8 DCT with 64 multiply-accumulators, output register and output strobe
module dct_col_stage import dct_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  row_vec_t    row_coefs,
	input  idx_t        row_idx,
	input  logic        row_valid,
	output coef_block_t coef_block,
	output logic        output_enable
);

	// Row coefficients split out of the packed vector, index u is frequency
	row_coef_t row_y [BLOCK_N];

	// First stage holds 64 products, indexed [v][u]
	col_acc_t prod_c1 [BLOCK_N][BLOCK_N];
	logic     valid_c1;
	idx_t     row_c1;

	// Second stage holds the 64 column sums
	col_acc_t acc_c2 [BLOCK_N][BLOCK_N];
	logic     valid_c2;
	idx_t     row_c2;

	always_comb begin
		for (int u = 0; u < BLOCK_N; u++) begin
			row_y[u] = row_coef_t'(row_coefs[u*ROW_COEF_W +: ROW_COEF_W]);
		end
	end

	// ------------------------------------------------------------------------
	// Products
	// ------------------------------------------------------------------------

	// Each row coefficient is weighted by the eight vertical constants of
	// the row it came from, so the row index picks one column of the table
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_c1 <= 1'b0;
			row_c1   <= '0;
			for (int v = 0; v < BLOCK_N; v++) begin
				for (int u = 0; u < BLOCK_N; u++) begin
					prod_c1[v][u] <= '0;
				end
			end
		end else begin
			valid_c1 <= row_valid;
			if (row_valid) begin
				row_c1 <= row_idx;
				for (int v = 0; v < BLOCK_N; v++) begin
					for (int u = 0; u < BLOCK_N; u++) begin
						prod_c1[v][u] <= row_y[u] * dct_cos(v, int'(row_idx));
					end
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Accumulation over the eight rows
	// ------------------------------------------------------------------------

	// Row 0 loads, so a block cut short earlier leaves nothing behind
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_c2 <= 1'b0;
			row_c2   <= '0;
			for (int v = 0; v < BLOCK_N; v++) begin
				for (int u = 0; u < BLOCK_N; u++) begin
					acc_c2[v][u] <= '0;
				end
			end
		end else begin
			valid_c2 <= valid_c1;
			row_c2   <= row_c1;
			if (valid_c1) begin
				for (int v = 0; v < BLOCK_N; v++) begin
					for (int u = 0; u < BLOCK_N; u++) begin
						if (row_c1 == '0) begin
							acc_c2[v][u] <= prod_c1[v][u];
						end else begin
							acc_c2[v][u] <= acc_c2[v][u] + prod_c1[v][u];
						end
					end
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Final rounding and output register
	// ------------------------------------------------------------------------

	// Once row 7 is in, keep bits 26..16 and round half up with bit 15
	// The block stays on the output until the next one overwrites it
	always_ff @(posedge clk) begin
		if (rst) begin
			output_enable <= 1'b0;
			coef_block    <= '0;
		end else begin
			output_enable <= valid_c2 && (row_c2 == IDX_LAST);
			if (valid_c2 && (row_c2 == IDX_LAST)) begin
				for (int v = 0; v < BLOCK_N; v++) begin
					for (int u = 0; u < BLOCK_N; u++) begin
						coef_block[(v*BLOCK_N+u)*DCT_COEF_W +: DCT_COEF_W] <=
							dct_coef_t'(acc_c2[v][u][COL_DROP +: DCT_COEF_W]) +
							dct_coef_t'(acc_c2[v][u][COL_DROP-1]);
					end
				end
			end
		end
	end

endmodule

// ==== verilog/dct_row_stage.sv ====
// Row pass of the 8x8 DCT with pixel counter, level shift and eight row multiply-accumulators
module dct_row_stage import dct_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     enable,
	input  pixel_t   data_in,
	output row_vec_t row_coefs,
	output idx_t     row_idx,
	output logic     row_valid
);

	// Position of the next pixel in its block, sample in the low bits
	logic [2*IDX_W-1:0] pos;

	// Stage 1 holds the level-shifted pixel
	shifted_t pix_s1;
	logic     valid_s1;
	idx_t     samp_s1;
	idx_t     row_s1;

	// Stage 2 holds the eight products of that pixel
	row_acc_t prod_s2 [BLOCK_N];
	logic     valid_s2;
	idx_t     samp_s2;
	idx_t     row_s2;

	// Stage 3 holds the running sums per frequency
	row_acc_t acc_s3 [BLOCK_N];
	logic     valid_s3;
	idx_t     samp_s3;
	idx_t     row_s3;

	// ------------------------------------------------------------------------
	// Input counting and level shift
	// ------------------------------------------------------------------------

	// Any idle cycle restarts the block at pixel 0
	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			pos <= '0;
		end else begin
			pos <= pos + 1'b1;
		end
	end

	// Sample the pixel, subtract 128 and tag it with its position
	// An idle cycle clears this stage so a partial row never reaches the output
	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			pix_s1   <= '0;
			valid_s1 <= 1'b0;
			samp_s1  <= '0;
			row_s1   <= '0;
		end else begin
			pix_s1   <= shifted_t'({1'b0, data_in}) - shifted_t'(LEVEL_SHIFT);
			valid_s1 <= 1'b1;
			samp_s1  <= pos[IDX_W-1:0];
			row_s1   <= pos[2*IDX_W-1:IDX_W];
		end
	end

	// ------------------------------------------------------------------------
	// Multiply and accumulate
	// ------------------------------------------------------------------------

	// One product per frequency, using the constants of this sample position
	// Stages past the input run on so a sampled row always finishes
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_s2 <= 1'b0;
			samp_s2  <= '0;
			row_s2   <= '0;
			for (int k = 0; k < BLOCK_N; k++) begin
				prod_s2[k] <= '0;
			end
		end else begin
			valid_s2 <= valid_s1;
			samp_s2  <= samp_s1;
			row_s2   <= row_s1;
			for (int k = 0; k < BLOCK_N; k++) begin
				prod_s2[k] <= pix_s1 * dct_cos(k, int'(samp_s1));
			end
		end
	end

	// Sample 0 loads the sums, later samples add to them
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_s3 <= 1'b0;
			samp_s3  <= '0;
			row_s3   <= '0;
			for (int k = 0; k < BLOCK_N; k++) begin
				acc_s3[k] <= '0;
			end
		end else begin
			valid_s3 <= valid_s2;
			samp_s3  <= samp_s2;
			row_s3   <= row_s2;
			if (valid_s2) begin
				for (int k = 0; k < BLOCK_N; k++) begin
					if (samp_s2 == '0) begin
						acc_s3[k] <= prod_s2[k];
					end else begin
						acc_s3[k] <= acc_s3[k] + prod_s2[k];
					end
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Rounding and row strobe
	// ------------------------------------------------------------------------

	// After the eighth sample, keep bits 24..12 and round half up with bit 11
	// The coefficients then hold until the next row completes
	always_ff @(posedge clk) begin
		if (rst) begin
			row_valid <= 1'b0;
			row_idx   <= '0;
			row_coefs <= '0;
		end else begin
			row_valid <= valid_s3 && (samp_s3 == IDX_LAST);
			if (valid_s3 && (samp_s3 == IDX_LAST)) begin
				row_idx <= row_s3;
				for (int k = 0; k < BLOCK_N; k++) begin
					row_coefs[k*ROW_COEF_W +: ROW_COEF_W] <=
						row_coef_t'(acc_s3[k][ROW_DROP +: ROW_COEF_W]) +
						row_coef_t'(acc_s3[k][ROW_DROP-1]);
				end
			end
		end
	end

endmodule

// ==== verilog/dct_pkg.sv ====
// DCT widths, typedefs, scaling constants, the last-index constant and the cosine table function
package dct_pkg;

	// ------------------------------------------------------------------------
	// Transform geometry and fixed-point scaling
	// ------------------------------------------------------------------------

	// One block is eight rows of eight pixels
	localparam int BLOCK_N     = 8;
	localparam int IDX_W       = $clog2(BLOCK_N);
	// Unsigned pixels are centred on zero before the row pass
	localparam int LEVEL_SHIFT = 128;
	// Cosine constants carry 13 fraction bits, plus one sign bit
	localparam int COEF_FRAC   = 13;
	localparam int COS_W       = COEF_FRAC + 1;
	// Bits cut after each pass, rounded half up by the bit below the cut
	localparam int ROW_DROP    = 12;
	localparam int COL_DROP    = 16;

	// Datapath widths
	localparam int PIXEL_W     = 8;
	localparam int SHIFT_W     = PIXEL_W + 1;
	localparam int ROW_ACC_W   = 25;
	localparam int ROW_COEF_W  = ROW_ACC_W - ROW_DROP;
	localparam int COL_ACC_W   = 32;
	localparam int DCT_COEF_W  = 11;

	// ------------------------------------------------------------------------
	// Types
	// ------------------------------------------------------------------------
	typedef logic        [PIXEL_W-1:0]    pixel_t;
	typedef logic signed [SHIFT_W-1:0]    shifted_t;
	typedef logic signed [COS_W-1:0]      cos_const_t;
	typedef logic signed [ROW_ACC_W-1:0]  row_acc_t;
	typedef logic signed [ROW_COEF_W-1:0] row_coef_t;
	// Eight row coefficients, frequency 0 in the low slice
	typedef logic [BLOCK_N*ROW_COEF_W-1:0] row_vec_t;
	typedef logic signed [COL_ACC_W-1:0]  col_acc_t;
	typedef logic signed [DCT_COEF_W-1:0] dct_coef_t;
	// Coefficient (v,u) sits at slice v*8+u
	typedef logic [BLOCK_N*BLOCK_N*DCT_COEF_W-1:0] coef_block_t;
	typedef logic [IDX_W-1:0] idx_t;

	// Index of the last sample in a row and of the last row in a block
	localparam idx_t IDX_LAST = idx_t'(BLOCK_N - 1);

	// ------------------------------------------------------------------------
	// Cosine table
	// ------------------------------------------------------------------------

	// Constant for frequency k and sample n, 8192*cos((2n+1)k*pi/16)
	// The DC row uses 1/sqrt(2), which is the same value as cos(pi/4)
	function automatic cos_const_t dct_cos(input int k, input int n);
		int   m;
		int   mag;
		logic neg;
		// Phase in units of pi/16, folded into one full period
		m = ((2 * n + 1) * k) % (4 * BLOCK_N);
		neg = 1'b0;
		if (k == 0) begin
			m = BLOCK_N / 2;
		end
		// Cosine is even around a full period
		if (m > 2 * BLOCK_N) begin
			m = 4 * BLOCK_N - m;
		end
		// Past a quarter period the value mirrors with a sign change
		if (m > BLOCK_N) begin
			m = 2 * BLOCK_N - m;
			neg = 1'b1;
		end
		case (m)
			1:       mag = 8035;
			2:       mag = 7568;
			3:       mag = 6811;
			4:       mag = 5793;
			5:       mag = 4551;
			6:       mag = 3135;
			7:       mag = 1598;
			// Phases 0 and 8 never occur for k from 1 to 7
			default: mag = 0;
		endcase
		return neg ? cos_const_t'(-mag) : cos_const_t'(mag);
	endfunction

endpackage
